//--- logic/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

    localparam int WORD_LEN = 32;                   // Extension rules assume 32 bits

    typedef logic [WORD_LEN-1:0] word_t;
    typedef logic [31:0]         addr_t;            // Byte address
    typedef logic [7:0]          byte_t;            // One memory cell

    // Fourth code is left unnamed and always faults
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    typedef struct packed {
        logic         valid;
        logic         write;                        // 1 store, 0 load
        access_size_e size;
        logic         is_unsigned;                  // Zero-extend loads
        addr_t        addr;
        word_t        wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        logic  fault;
        word_t rdata;                               // Zero for stores and faults
    } mem_rsp_t;

    // Bytes touched by an access, illegal size counted as one byte
    function automatic logic [2:0] size_len(access_size_e size);
        logic [2:0] len;
        case (size)
            SIZE_HALF: len = 3'd2;
            SIZE_WORD: len = 3'd4;
            default:   len = 3'd1;
        endcase
        return len;
    endfunction

endpackage

`default_nettype wire

//--- logic/mem_csr_pkg.sv
`default_nettype none

package mem_csr_pkg;

    import mem_types_pkg::*;

    // Register map of the configuration port
    typedef enum logic [1:0] {
        CSR_CTRL        = 2'd0,
        CSR_FAULT_ADDR  = 2'd1,                     // Read-only
        CSR_FAULT_COUNT = 2'd2                      // Write clears
    } csr_addr_e;

    typedef struct packed {
        logic strict_align;                         // Misaligned access faults when set
    } csr_ctrl_t;

    typedef struct packed {
        logic  pulse;                               // High in the faulting request cycle
        addr_t addr;
    } fault_info_t;

endpackage

`default_nettype wire

//--- logic/access_checker.sv
`default_nettype none

module access_checker
    import mem_types_pkg::*;
    import mem_csr_pkg::*;
#(
    parameter int DATA_MEM_SIZE = 1024
) (
    input  wire mem_req_t i_req,
    input  wire logic     i_strict,
    output logic          o_fault,
    output logic          o_write_ok,
    output fault_info_t   o_fault_info
);

    logic [2:0]  acc_len;
    logic        size_bad;
    logic [32:0] last_byte;                         // Extra bit catches address wrap
    logic        range_fault;
    logic        align_fault;

    assign acc_len  = size_len(i_req.size);
    assign size_bad = !(i_req.size inside {SIZE_BYTE, SIZE_HALF, SIZE_WORD});

    // Address of the last byte the access touches
    assign last_byte   = {1'b0, i_req.addr} + 33'(acc_len) - 33'd1;
    assign range_fault = last_byte >= 33'(DATA_MEM_SIZE);   // Also true on wrap

    // Low address bits must be clear for the access length
    assign align_fault = i_strict && ((i_req.addr[1:0] & 2'(acc_len - 3'd1)) != 2'b00);

    assign o_fault    = i_req.valid && (size_bad || range_fault || align_fault);
    assign o_write_ok = i_req.valid && i_req.write && !o_fault;

    assign o_fault_info = '{pulse: o_fault, addr: i_req.addr};

    // A permitted store stays inside the array and aligned while strict
    write_legal: assert final (!o_write_ok
        || ((i_req.addr <= 32'(DATA_MEM_SIZE) - 32'(acc_len))
            && (!i_strict || (i_req.addr % 32'(acc_len)) == 32'd0)))
        else $error("access_checker: write permitted on an illegal access");

endmodule

`default_nettype wire

//--- logic/byte_ram.sv
`default_nettype none

module byte_ram
    import mem_types_pkg::*;
#(
    parameter int DATA_MEM_SIZE = 1024
) (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire mem_req_t i_req,
    input  wire logic     i_write_ok,
    output word_t         o_window
);

    localparam int ADDR_W = $clog2(DATA_MEM_SIZE);

    byte_t             mem [DATA_MEM_SIZE] = '{default: '0};  // RAM starts at zero
    logic [2:0]        wr_len;
    logic [ADDR_W-1:0] wr_idx [4];
    logic [32:0]       rd_pos [4];                  // Wide enough to see past the end
    word_t             rd_word;
    word_t             window_q;

    assign wr_len = size_len(i_req.size);

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            wr_idx[k] = i_req.addr[ADDR_W-1:0] + ADDR_W'(k);
        end
    end

    // Four bytes from addr upward, little-endian
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rd_pos[k] = {1'b0, i_req.addr} + 33'(k);
            if (rd_pos[k] < 33'(DATA_MEM_SIZE)) begin
                rd_word[8*k +: 8] = mem[rd_pos[k][ADDR_W-1:0]];
            end else begin
                rd_word[8*k +: 8] = '0;             // Past the end reads zero
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_write_ok) begin
            for (int k = 0; k < 4; k++) begin
                if (3'(k) < wr_len) begin
                    mem[wr_idx[k]] <= i_req.wdata[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            window_q <= '0;
        end else if (i_req.valid && !i_req.write) begin
            window_q <= rd_word;                    // Captured at the end of the load cycle
        end
    end

    assign o_window = window_q;

    // Checker permission must keep every stored byte inside the array
    wr_in_range: assert property (@(posedge i_clk) disable iff (i_rst)
        i_write_ok |-> (({1'b0, i_req.addr} + 33'(wr_len) - 33'd1) < 33'(DATA_MEM_SIZE)))
        else $error("byte_ram: store outside the array at %h", i_req.addr);

endmodule

`default_nettype wire

//--- logic/load_extender.sv
`default_nettype none

module load_extender
    import mem_types_pkg::*;
(
    input  wire word_t        i_window,
    input  wire access_size_e i_size,
    input  wire logic         i_unsigned,
    input  wire logic         i_load_ok,
    output word_t             o_rdata
);

    logic  sign;
    word_t ext_data;

    always_comb begin
        sign     = 1'b0;
        ext_data = i_window;                        // Word keeps all four bytes
        case (i_size)
            SIZE_BYTE: begin
                sign     = i_window[7] && !i_unsigned;
                ext_data = {{24{sign}}, i_window[7:0]};
            end
            SIZE_HALF: begin
                sign     = i_window[15] && !i_unsigned;
                ext_data = {{16{sign}}, i_window[15:0]};
            end
            default: begin
                ext_data = i_window;
            end
        endcase
    end

    // Stores and faulted loads return zero
    assign o_rdata = i_load_ok ? ext_data : '0;

endmodule

`default_nettype wire

//--- logic/mem_csr.sv
`default_nettype none

module mem_csr
    import mem_types_pkg::*;
    import mem_csr_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire logic        i_cfg_we,
    input  wire csr_addr_e   i_cfg_addr,
    input  wire word_t       i_cfg_wdata,
    input  wire fault_info_t i_fault_info,
    output csr_ctrl_t        o_ctrl,
    output word_t            o_cfg_rdata
);

    csr_ctrl_t ctrl_q;
    addr_t     fault_addr_q;                        // Address of the last fault
    word_t     fault_count_q;
    logic      count_clear;

    assign count_clear = i_cfg_we && (i_cfg_addr == CSR_FAULT_COUNT);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ctrl_q <= '0;
        end else if (i_cfg_we && (i_cfg_addr == CSR_CTRL)) begin
            ctrl_q.strict_align <= i_cfg_wdata[0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            fault_addr_q <= '0;
        end else if (i_fault_info.pulse) begin
            fault_addr_q <= i_fault_info.addr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            fault_count_q <= '0;
        end else if (i_fault_info.pulse) begin
            if (count_clear) begin
                fault_count_q <= 32'd1;             // Fault wins over a clear
            end else if (fault_count_q != '1) begin
                fault_count_q <= fault_count_q + 32'd1;
            end
        end else if (count_clear) begin
            fault_count_q <= '0;
        end
    end

    // Read mux has no side effects
    always_comb begin
        case (i_cfg_addr)
            CSR_CTRL:        o_cfg_rdata = {31'b0, ctrl_q.strict_align};
            CSR_FAULT_ADDR:  o_cfg_rdata = fault_addr_q;
            CSR_FAULT_COUNT: o_cfg_rdata = fault_count_q;
            default:         o_cfg_rdata = '0;
        endcase
    end

    assign o_ctrl = ctrl_q;

    // Only a clear may bring the counter down
    count_monotonic: assert property (@(posedge i_clk) disable iff (i_rst)
        !count_clear |=> (fault_count_q >= $past(fault_count_q)))
        else $error("mem_csr: fault counter decreased without a clear");

endmodule

`default_nettype wire

//--- logic/lsu_mem_top.sv
`default_nettype none

module lsu_mem_top
    import mem_types_pkg::*;
    import mem_csr_pkg::*;
#(
    parameter int DATA_MEM_SIZE = 1024
) (
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire mem_req_t  i_req,
    output mem_rsp_t       o_rsp,
    input  wire logic      i_cfg_we,
    input  wire logic      i_cfg_re,
    input  wire csr_addr_e i_cfg_addr,
    input  wire word_t     i_cfg_wdata,
    output word_t          o_cfg_rdata
);

    csr_ctrl_t    ctrl;
    logic         req_fault;
    logic         write_ok;
    fault_info_t  fault_info;
    word_t        window;
    word_t        load_data;
    logic         load_ok;

    logic         rsp_valid_q;
    logic         rsp_fault_q;
    logic         load_ok_q;
    access_size_e size_q;
    logic         unsigned_q;

    access_checker #(.DATA_MEM_SIZE(DATA_MEM_SIZE)) checker_i (
        .i_req        (i_req),
        .i_strict     (ctrl.strict_align),
        .o_fault      (req_fault),
        .o_write_ok   (write_ok),
        .o_fault_info (fault_info)
    );

    byte_ram #(.DATA_MEM_SIZE(DATA_MEM_SIZE)) ram_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_req      (i_req),
        .i_write_ok (write_ok),
        .o_window   (window)
    );

    mem_csr csr_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_cfg_we     (i_cfg_we),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .i_fault_info (fault_info),
        .o_ctrl       (ctrl),
        .o_cfg_rdata  (o_cfg_rdata)
    );

    assign load_ok = i_req.valid && !i_req.write && !req_fault;

    // Response stage, one cycle behind the request
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rsp_valid_q <= 1'b0;
            rsp_fault_q <= 1'b0;
            load_ok_q   <= 1'b0;
        end else begin
            rsp_valid_q <= i_req.valid;
            rsp_fault_q <= req_fault;
            load_ok_q   <= load_ok;
        end
    end

    always_ff @(posedge i_clk) begin
        size_q     <= i_req.size;                   // Payload only, qualified by load_ok_q
        unsigned_q <= i_req.is_unsigned;
    end

    load_extender extender_i (
        .i_window   (window),
        .i_size     (size_q),
        .i_unsigned (unsigned_q),
        .i_load_ok  (load_ok_q),
        .o_rdata    (load_data)
    );

    assign o_rsp = '{valid: rsp_valid_q, fault: rsp_fault_q, rdata: load_data};

    // Faulted response carries no data, across checker, stage and extender
    rsp_fault_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rsp.fault |-> (o_rsp.rdata == '0))
        else $error("lsu_mem_top: faulted response with nonzero data");

    cfg_read_known: assert property (@(posedge i_clk) disable iff (i_rst)
        i_cfg_re |-> !$isunknown(o_cfg_rdata))
        else $error("lsu_mem_top: unknown config read data");

endmodule

`default_nettype wire

//--- testbench/tb_lsu_mem.sv
`default_nettype none

module tb_lsu_mem
    import mem_types_pkg::*;
    import mem_csr_pkg::*;
;

    localparam int          MEM_BYTES    = 256;
    localparam int          CLK_PERIOD   = 20;
    localparam int          NUM_RANDOM   = 300;
    localparam int          NUM_DIRECTED = 80;          // Directed requests, sweep and CSR cycles
    localparam int          TOTAL_REQS   = NUM_RANDOM + NUM_DIRECTED;
    localparam logic [31:0] RAND_SEED    = 32'h733849d7;

    logic      clk;
    logic      rst;
    mem_req_t  req;
    mem_rsp_t  rsp;
    logic      cfg_we;
    logic      cfg_re;
    csr_addr_e cfg_addr;
    word_t     cfg_wdata;
    word_t     cfg_rdata;

    byte_t     ref_mem [MEM_BYTES] = '{default: '0};    // Byte-array model of the RAM
    logic      ref_strict;
    word_t     ref_count;
    addr_t     ref_fault_addr;
    mem_rsp_t  req_exp;                                 // Expectation of the request in the DUT
    mem_rsp_t  exp_q;                                   // Expectation of the visible response

    lsu_mem_top #(.DATA_MEM_SIZE(MEM_BYTES)) dut_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_req       (req),
        .o_rsp       (rsp),
        .i_cfg_we    (cfg_we),
        .i_cfg_re    (cfg_re),
        .i_cfg_addr  (cfg_addr),
        .i_cfg_wdata (cfg_wdata),
        .o_cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Expected response from the little-endian byte model and the access rules
    function automatic mem_rsp_t expect_rsp(mem_req_t r);
        mem_rsp_t    e;
        int          len;
        logic [32:0] last;
        logic        bad;
        word_t       raw;
        logic        sgn;
        e = '0;
        e.valid = r.valid;
        case (r.size)
            SIZE_BYTE: len = 1;
            SIZE_HALF: len = 2;
            SIZE_WORD: len = 4;
            default:   len = 0;                         // Fourth code always faults
        endcase
        bad = (len == 0);
        last = {1'b0, r.addr} + 33'(len) - 33'd1;
        if (!bad && last >= 33'(MEM_BYTES)) bad = 1'b1;
        if (!bad && ref_strict && (r.addr % len) != 0) bad = 1'b1;
        e.fault = r.valid && bad;
        if (r.valid && !r.write && !bad) begin
            raw = '0;
            for (int k = 0; k < len; k++) raw[8*k +: 8] = ref_mem[int'(r.addr) + k];
            sgn = !r.is_unsigned && raw[8*len-1];      // Top bit of the highest byte read
            for (int k = 8*len; k < 32; k++) raw[k] = sgn;
            e.rdata = raw;
        end
        return e;
    endfunction

    task automatic update_model(input mem_req_t r, input logic fault);
        int len;
        len = (r.size == SIZE_WORD) ? 4 : (r.size == SIZE_HALF) ? 2 : 1;
        if (fault) begin
            ref_fault_addr = r.addr;
            if (ref_count != '1) ref_count = ref_count + 1;
        end else if (r.write) begin
            for (int k = 0; k < len; k++) ref_mem[int'(r.addr) + k] = r.wdata[8*k +: 8];
        end
    endtask

    task automatic issue(input logic wr, input access_size_e size, input logic uns,
                         input addr_t addr, input word_t wdata);
        mem_req_t r;
        mem_rsp_t e;
        r = '{valid: 1'b1, write: wr, size: size, is_unsigned: uns, addr: addr, wdata: wdata};
        @(posedge clk);
        e = expect_rsp(r);
        req     <= r;
        req_exp <= e;
        update_model(r, e.fault);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            req     <= '0;
            req_exp <= '0;
        end
    endtask

    task automatic cfg_write(input csr_addr_e addr, input word_t data);
        idle(1);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
        if (addr == CSR_CTRL) ref_strict = data[0];
        if (addr == CSR_FAULT_COUNT) ref_count = '0;   // Written value ignored
    endtask

    task automatic cfg_read(input csr_addr_e addr, input word_t expected, input string what);
        idle(1);
        cfg_re   <= 1'b1;
        cfg_addr <= addr;
        @(negedge clk);
        check_eq(cfg_rdata, expected, what);
        @(posedge clk);
        cfg_re <= 1'b0;
    endtask

    // Response pipeline and compare, sampled mid-cycle
    always @(posedge clk) exp_q <= req_exp;

    always @(negedge clk) begin
        if (!rst) begin
            check_eq(32'(rsp.valid), 32'(exp_q.valid), "response valid");
            if (exp_q.valid) begin
                check_eq(32'(rsp.fault), 32'(exp_q.fault), "response fault");
                check_eq(rsp.rdata, exp_q.rdata, "response rdata");
            end
        end
    end

    initial begin
        #(20 * TOTAL_REQS * CLK_PERIOD);
        $display("Watchdog expired: the test did not finish in the expected time");
        $display("Errors found");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        access_size_e sz;
        void'($urandom(RAND_SEED));
        rst            = 1'b1;
        req            = '0;
        cfg_we         = 1'b0;
        cfg_re         = 1'b0;
        cfg_addr       = CSR_CTRL;
        cfg_wdata      = '0;
        req_exp        = '0;
        exp_q          = '0;
        ref_strict     = 1'b0;
        ref_count      = '0;
        ref_fault_addr = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idle(2);

        // Aligned word store, then load in the next cycle
        issue(1'b1, SIZE_WORD, 1'b0, 32'h10, 32'hdeadbeef);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h0);

        // Sign and zero extension of byte and half loads
        issue(1'b1, SIZE_WORD, 1'b0, 32'h20, 32'h80ff7f80);
        for (int k = 0; k < 4; k++) begin
            issue(1'b0, SIZE_BYTE, 1'b0, 32'h20 + k, 32'h0);
            issue(1'b0, SIZE_BYTE, 1'b1, 32'h20 + k, 32'h0);
        end
        issue(1'b0, SIZE_HALF, 1'b0, 32'h22, 32'h0);
        issue(1'b0, SIZE_HALF, 1'b1, 32'h22, 32'h0);
        issue(1'b0, SIZE_HALF, 1'b0, 32'h20, 32'h0);

        // Mixed random traffic near the end of the memory
        for (int n = 0; n < NUM_RANDOM; n++) begin
            sz = access_size_e'(2'($urandom_range(0, 2)));
            if ($urandom_range(0, 31) == 0) sz = access_size_e'(2'b11);   // Illegal code
            issue(1'($urandom_range(0, 1)), sz, 1'($urandom_range(0, 1)),
                  32'hc0 + $urandom_range(0, 63), $urandom);
        end
        for (int a = 32'hc0; a < MEM_BYTES; a += 4) begin
            issue(1'b0, SIZE_WORD, 1'b0, a, 32'h0);    // Neighbor bytes intact
        end

        // Misaligned access, permitted then strict
        issue(1'b1, SIZE_WORD, 1'b0, 32'h31, 32'h44332211);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h31, 32'h0);
        issue(1'b0, SIZE_HALF, 1'b0, 32'h33, 32'h0);
        cfg_write(CSR_CTRL, 32'h1);
        cfg_read(CSR_CTRL, 32'h1, "strict bit readback");
        issue(1'b1, SIZE_WORD, 1'b0, 32'h31, 32'haabbccdd);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h31, 32'h0);
        issue(1'b0, SIZE_HALF, 1'b0, 32'h33, 32'h0);
        issue(1'b1, SIZE_HALF, 1'b0, 32'h35, 32'h5566);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h30, 32'h0);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h34, 32'h0);
        cfg_write(CSR_CTRL, 32'h0);

        // Range faults regardless of strict, then fault registers
        issue(1'b0, SIZE_WORD, 1'b0, 32'hfe, 32'h0);
        issue(1'b1, SIZE_HALF, 1'b0, 32'hff, 32'h1234);
        issue(1'b1, SIZE_BYTE, 1'b0, 32'hff, 32'h9a);
        issue(1'b0, SIZE_BYTE, 1'b0, 32'hff, 32'h0);
        issue(1'b0, SIZE_WORD, 1'b0, 32'hfffffffe, 32'h0);   // Wraps past the top
        issue(1'b1, SIZE_WORD, 1'b0, 32'h100, 32'h0);
        idle(2);
        cfg_read(CSR_FAULT_ADDR, ref_fault_addr, "fault address");
        cfg_read(CSR_FAULT_COUNT, ref_count, "fault count");
        cfg_write(CSR_FAULT_COUNT, 32'hffff);
        cfg_read(CSR_FAULT_COUNT, 32'h0, "fault count after clear");
        idle(3);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu_mem.f
logic/mem_types_pkg.sv
logic/mem_csr_pkg.sv
logic/access_checker.sv
logic/byte_ram.sv
logic/load_extender.sv
logic/mem_csr.sv
logic/lsu_mem_top.sv
testbench/tb_lsu_mem.sv
